/* logic/mips_isa_pkg.sv */
package mips_isa_pkg;

    typedef logic [31:0] word_t;     // data or address word
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;

    // primary opcodes
    localparam opcode_t op_special = 6'h00;
    localparam opcode_t op_j       = 6'h02;
    localparam opcode_t op_jal     = 6'h03;
    localparam opcode_t op_beq     = 6'h04;
    localparam opcode_t op_bne     = 6'h05;
    localparam opcode_t op_addiu   = 6'h09;
    localparam opcode_t op_slti    = 6'h0a;
    localparam opcode_t op_sltiu   = 6'h0b;
    localparam opcode_t op_andi    = 6'h0c;
    localparam opcode_t op_ori     = 6'h0d;
    localparam opcode_t op_xori    = 6'h0e;
    localparam opcode_t op_lui     = 6'h0f;
    localparam opcode_t op_lb      = 6'h20;
    localparam opcode_t op_lh      = 6'h21;
    localparam opcode_t op_lw      = 6'h23;
    localparam opcode_t op_lbu     = 6'h24;
    localparam opcode_t op_lhu     = 6'h25;
    localparam opcode_t op_sb      = 6'h28;
    localparam opcode_t op_sh      = 6'h29;
    localparam opcode_t op_sw      = 6'h2b;

    // special (r-type) function codes
    localparam funct_t fn_sll  = 6'h00;
    localparam funct_t fn_srl  = 6'h02;
    localparam funct_t fn_sra  = 6'h03;
    localparam funct_t fn_jr   = 6'h08;
    localparam funct_t fn_jalr = 6'h09;
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_nor  = 6'h27;
    localparam funct_t fn_slt  = 6'h2a;
    localparam funct_t fn_sltu = 6'h2b;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_t;

    typedef enum logic [1:0] {wb_alu, wb_load, wb_link} wb_src_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      alu_src_imm;
        logic      imm_signed;
        logic      reg_dst_rd;
        logic      link;          // destination is $31
        logic      reg_write;
        mem_size_t mem_size;
        logic      load_signed;
        wb_src_t   wb_src;
        logic      branch;
        logic      branch_ne;
        logic      jump;
        logic      jump_reg;
        logic      ir_write;
        logic      pc_write;
        logic      bus_read;
        logic      bus_write;
        logic      addr_from_pc;
    } ctrl_t;

endpackage

/* logic/cpu_bus_pkg.sv */
package cpu_bus_pkg;

    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  byte_en_t;    // one bit per byte lane

    // master to slave
    typedef struct packed {
        bus_addr_t address;     // always word aligned
        logic      read;
        logic      write;
        bus_data_t writedata;
        byte_en_t  byteenable;
    } avalon_req_t;

    // slave to master
    typedef struct packed {
        bus_data_t readdata;    // valid when waitrequest is low
        logic      waitrequest;
    } avalon_rsp_t;

endpackage

/* logic/control_unit.sv */
module control_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  mips_isa_pkg::word_t instr,
    input  logic                zero,
    input  logic                waitrequest,
    input  logic                pc_is_zero,
    output logic                active,
    output mips_isa_pkg::ctrl_t ctrl
);
    import mips_isa_pkg::*;

    typedef enum logic [2:0] {
        st_halted, st_start, st_fetch, st_decode, st_execute, st_mem
    } state_t;

    state_t  state;
    state_t  state_next;
    ctrl_t   dec;          // decoded fields, not yet qualified by state
    opcode_t opcode;
    funct_t  funct;
    logic    advance;
    logic    is_mem;
    logic    retire;       // last cycle of the instruction

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign advance = !waitrequest;
    assign is_mem  = dec.bus_read | dec.bus_write;
    assign retire  = advance && (is_mem ? state == st_mem : state == st_execute);

    always_comb begin
        case (state)
            st_halted:  state_next = pc_is_zero ? st_halted : st_start;
            st_start:   state_next = st_fetch;
            st_fetch:   state_next = pc_is_zero ? st_halted : st_decode;  // jump to 0 ends the run
            st_decode:  state_next = st_execute;
            st_execute: state_next = is_mem ? st_mem : st_fetch;
            st_mem:     state_next = st_fetch;
            default:    state_next = st_halted;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= st_halted;
            active <= 1'b0;
        end else if (advance) begin
            state  <= state_next;
            active <= state_next != st_halted;
        end
    end

    // instruction decoder
    always_comb begin
        dec          = '0;
        dec.alu_op   = alu_add;
        dec.mem_size = size_word;
        dec.wb_src   = wb_alu;
        case (opcode)
            op_special: begin
                dec.reg_dst_rd = 1'b1;
                dec.reg_write  = 1'b1;
                case (funct)
                    fn_addu: dec.alu_op = alu_add;
                    fn_subu: dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_or:   dec.alu_op = alu_or;
                    fn_xor:  dec.alu_op = alu_xor;
                    fn_nor:  dec.alu_op = alu_nor;
                    fn_slt:  dec.alu_op = alu_slt;
                    fn_sltu: dec.alu_op = alu_sltu;
                    fn_sll:  dec.alu_op = alu_sll;
                    fn_srl:  dec.alu_op = alu_srl;
                    fn_sra:  dec.alu_op = alu_sra;
                    fn_jr: begin
                        dec.jump      = 1'b1;
                        dec.jump_reg  = 1'b1;
                        dec.reg_write = 1'b0;
                    end
                    fn_jalr: begin
                        dec.jump     = 1'b1;
                        dec.jump_reg = 1'b1;
                        dec.wb_src   = wb_link;
                    end
                    default: dec.reg_write = 1'b0;  // unsupported funct acts as nop
                endcase
            end
            op_j:   dec.jump = 1'b1;
            op_jal: begin
                dec.jump      = 1'b1;
                dec.link      = 1'b1;
                dec.reg_write = 1'b1;
                dec.wb_src    = wb_link;
            end
            op_beq, op_bne: begin
                dec.alu_op    = alu_sub;    // compare by subtraction
                dec.branch    = 1'b1;
                dec.branch_ne = opcode == op_bne;
            end
            op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                dec.imm_signed  = opcode inside {op_addiu, op_slti, op_sltiu};
                case (opcode)
                    op_slti:  dec.alu_op = alu_slt;
                    op_sltiu: dec.alu_op = alu_sltu;
                    op_andi:  dec.alu_op = alu_and;
                    op_ori:   dec.alu_op = alu_or;
                    op_xori:  dec.alu_op = alu_xor;
                    op_lui:   dec.alu_op = alu_lui;
                    default:  dec.alu_op = alu_add;
                endcase
            end
            op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
                dec.alu_src_imm = 1'b1;
                dec.imm_signed  = 1'b1;
                dec.reg_write   = 1'b1;
                dec.wb_src      = wb_load;
                dec.bus_read    = 1'b1;
                dec.load_signed = opcode inside {op_lb, op_lh};
                dec.mem_size    = opcode inside {op_lb, op_lbu} ? size_byte :
                                  opcode inside {op_lh, op_lhu} ? size_half : size_word;
            end
            op_sb, op_sh, op_sw: begin
                dec.alu_src_imm = 1'b1;
                dec.imm_signed  = 1'b1;
                dec.bus_write   = 1'b1;
                dec.mem_size    = opcode == op_sb ? size_byte :
                                  opcode == op_sh ? size_half : size_word;
            end
            default: ;
        endcase
    end

    // qualify by state and bus progress
    always_comb begin
        ctrl              = dec;
        ctrl.addr_from_pc = state == st_fetch;
        ctrl.ir_write     = state == st_fetch && advance && !pc_is_zero;
        ctrl.bus_read     = (state == st_fetch && !pc_is_zero) || (state == st_mem && dec.bus_read);
        ctrl.bus_write    = state == st_mem && dec.bus_write;
        ctrl.branch       = dec.branch && (zero ^ dec.branch_ne) && advance
                            && state == st_execute;
        ctrl.jump         = dec.jump && advance && state == st_execute;
        ctrl.reg_write    = dec.reg_write && retire;
        ctrl.pc_write     = retire;
    end

endmodule

/* logic/register_file.sv */
module register_file (
    input  logic                   clk,
    input  logic                   arst_n,
    input  mips_isa_pkg::reg_idx_t rs_idx,
    input  mips_isa_pkg::reg_idx_t rt_idx,
    input  mips_isa_pkg::reg_idx_t wr_idx,
    input  logic                   wr_en,
    input  mips_isa_pkg::word_t    wr_data,
    output mips_isa_pkg::word_t    rs_data,
    output mips_isa_pkg::word_t    rt_data,
    output mips_isa_pkg::word_t    v0
);
    import mips_isa_pkg::*;

    word_t regs [32];

    // reads are combinational
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];
    assign v0      = regs[2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin  // $0 stays zero
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

/* logic/alu.sv */
module alu (
    input  mips_isa_pkg::word_t   a,
    input  mips_isa_pkg::word_t   b,
    input  mips_isa_pkg::shamt_t  shamt,
    input  mips_isa_pkg::alu_op_t op,
    output mips_isa_pkg::word_t   result,
    output logic                  zero
);
    import mips_isa_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_nor:  result = ~(a | b);
            alu_slt:  result = {31'b0, lt_signed};
            alu_sltu: result = {31'b0, lt_unsigned};
            // shifts act on the rt operand
            alu_sll:  result = b << shamt;
            alu_srl:  result = b >> shamt;
            alu_sra:  result = $signed(b) >>> shamt;
            alu_lui:  result = {b[15:0], 16'h0000};
            default:  result = a + b;
        endcase
    end

    assign zero = result == '0;  // beq/bne compare

endmodule

/* logic/load_store_align.sv */
module load_store_align (
    input  logic [1:0]                addr_low,
    input  mips_isa_pkg::mem_size_t   size,
    input  logic                      load_signed,
    input  mips_isa_pkg::word_t       store_data,
    input  mips_isa_pkg::word_t       readdata,
    output mips_isa_pkg::word_t       writedata,
    output cpu_bus_pkg::byte_en_t     byteenable,
    output mips_isa_pkg::word_t       load_data
);
    import mips_isa_pkg::*;

    logic [15:0] half_sel;
    logic [7:0]  byte_sel;

    // store side, little-endian lanes
    always_comb begin
        case (size)
            size_byte: begin
                writedata  = {4{store_data[7:0]}};
                byteenable = 4'b0001 << addr_low;
            end
            size_half: begin
                writedata  = {2{store_data[15:0]}};
                byteenable = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                writedata  = store_data;
                byteenable = 4'b1111;
            end
        endcase
    end

    // load side
    assign half_sel = addr_low[1] ? readdata[31:16] : readdata[15:0];
    assign byte_sel = addr_low[0] ? half_sel[15:8] : half_sel[7:0];

    always_comb begin
        case (size)
            size_byte: load_data = {{24{load_signed & byte_sel[7]}}, byte_sel};
            size_half: load_data = {{16{load_signed & half_sel[15]}}, half_sel};
            default:   load_data = readdata;
        endcase
    end

endmodule

/* logic/mips_cpu_bus.sv */
module mips_cpu_bus #(
    parameter mips_isa_pkg::word_t reset_vector = 32'hbfc0_0000
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  cpu_bus_pkg::avalon_rsp_t bus_rsp,
    output logic                     active,
    output mips_isa_pkg::word_t      register_v0,
    output cpu_bus_pkg::avalon_req_t bus_req
);
    import mips_isa_pkg::*;
    import cpu_bus_pkg::*;

    ctrl_t    ctrl;
    word_t    pc;
    word_t    pc_plus4;
    word_t    instr_reg;
    word_t    delay_target;      // where the pc goes after the delay slot
    logic     delay_pending;
    word_t    branch_target;
    word_t    jump_target;
    word_t    next_target;
    word_t    imm_ext;
    word_t    rs_data;
    word_t    rt_data;
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_zero;
    word_t    load_data;
    word_t    store_lanes;
    byte_en_t lane_en;
    word_t    mem_addr;
    reg_idx_t wr_idx;
    word_t    wb_data;

    control_unit ctrl0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr_reg),
        .zero        (alu_zero),
        .waitrequest (bus_rsp.waitrequest),
        .pc_is_zero  (pc == '0),
        .active      (active),
        .ctrl        (ctrl)
    );

    // instruction register, loaded as the fetch completes
    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            instr_reg <= bus_rsp.readdata;
        end
    end

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{instr_reg[15]}}, instr_reg[15:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], instr_reg[25:0], 2'b00};
    assign next_target   = ctrl.branch   ? branch_target :
                           ctrl.jump_reg ? rs_data : jump_target;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc            <= reset_vector;
            delay_pending <= 1'b0;
        end else begin
            if (ctrl.pc_write) begin
                pc <= delay_pending ? delay_target : pc_plus4;
            end
            if (ctrl.branch || ctrl.jump) begin
                delay_pending <= 1'b1;   // taken, delay slot runs first
            end else if (ctrl.pc_write) begin
                delay_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.branch || ctrl.jump) begin
            delay_target <= next_target;
        end
    end

    register_file regs0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (instr_reg[25:21]),
        .rt_idx  (instr_reg[20:16]),
        .wr_idx  (wr_idx),
        .wr_en   (ctrl.reg_write),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    assign imm_ext = ctrl.imm_signed ? {{16{instr_reg[15]}}, instr_reg[15:0]}
                                     : {16'h0000, instr_reg[15:0]};
    assign alu_b   = ctrl.alu_src_imm ? imm_ext : rt_data;

    alu alu0 (
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (instr_reg[10:6]),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    load_store_align lsa0 (
        .addr_low    (alu_result[1:0]),
        .size        (ctrl.mem_size),
        .load_signed (ctrl.load_signed),
        .store_data  (rt_data),
        .readdata    (bus_rsp.readdata),
        .writedata   (store_lanes),
        .byteenable  (lane_en),
        .load_data   (load_data)
    );

    // destination: $31 for jal, rd for r-type, else rt
    assign wr_idx = ctrl.link       ? 5'd31 :
                    ctrl.reg_dst_rd ? instr_reg[15:11] : instr_reg[20:16];

    always_comb begin
        case (ctrl.wb_src)
            wb_load: wb_data = load_data;
            wb_link: wb_data = pc + 32'd8;   // skips the delay slot
            default: wb_data = alu_result;
        endcase
    end

    assign mem_addr = ctrl.addr_from_pc ? pc : alu_result;

    assign bus_req.address    = {mem_addr[31:2], 2'b00};
    assign bus_req.read       = ctrl.bus_read;
    assign bus_req.write      = ctrl.bus_write;
    assign bus_req.writedata  = store_lanes;
    assign bus_req.byteenable = ctrl.addr_from_pc ? 4'b1111 : lane_en;  // fetch reads the whole word

endmodule

/* bench/avalon_mem_model.sv */
module avalon_mem_model (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     stall_en,
    input  cpu_bus_pkg::avalon_req_t bus_req,
    output cpu_bus_pkg::avalon_rsp_t bus_rsp
);
    import cpu_bus_pkg::*;

    bus_data_t mem [bit [29:0]];     // sparse, keyed by word address
    bus_data_t lcg_state = 32'h7c80;
    bus_data_t rdata_q   = '0;
    logic      wait_q    = 1'b0;
    logic      busy      = 1'b0;      // a transfer has drawn its stall count
    int        remaining = 0;

    assign bus_rsp = {rdata_q, wait_q};

    function automatic bus_data_t lcg_next(input bus_data_t s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // untouched words read back as a pattern of their full address
    function automatic bus_data_t fill_word(input bit [29:0] idx);
        return {idx, 2'b00} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic void clear();
        mem.delete();
    endfunction

    function automatic void poke(input bus_addr_t addr, input bus_data_t data);
        mem[addr[31:2]] = data;
    endfunction

    function automatic bus_data_t peek(input bus_addr_t addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return fill_word(addr[31:2]);
    endfunction

    // responses change on the falling edge, the CPU samples on the rising one
    always @(negedge clk or negedge arst_n) begin
        bus_data_t word;
        if (!arst_n) begin
            busy      = 1'b0;
            remaining = 0;
            wait_q    = 1'b0;
        end else if (bus_req.read || bus_req.write) begin
            if (!busy) begin
                busy      = 1'b1;
                lcg_state = lcg_next(lcg_state);
                remaining = stall_en ? int'((lcg_state >> 16) % 3) : 0;  // 0 to 2 stalls
            end
            if (remaining > 0) begin
                wait_q = 1'b1;
                remaining--;
            end else begin
                wait_q = 1'b0;
                busy   = 1'b0;
                word   = peek(bus_req.address);
                if (bus_req.write) begin
                    for (int i = 0; i < 4; i++) begin
                        if (bus_req.byteenable[i]) begin
                            word[8*i +: 8] = bus_req.writedata[8*i +: 8];
                        end
                    end
                    poke(bus_req.address, word);
                end
                rdata_q = word;
            end
        end else begin
            wait_q = 1'b0;  // idle bus never stalls
        end
    end

endmodule

/* bench/mips_cpu_bus_tb.sv */
module mips_cpu_bus_tb;
    import mips_isa_pkg::*;
    import cpu_bus_pkg::*;

    localparam word_t reset_vector = 32'hbfc0_0000;
    localparam int    num_rows     = 7;
    localparam int    max_len      = 24;
    localparam int    cycle_limit  = 2 * num_rows * max_len * 12;  // two passes

    logic        clk;
    logic        arst_n;
    logic        stall_en;
    logic        active;
    word_t       register_v0;
    avalon_req_t bus_req;
    avalon_rsp_t bus_rsp;

    // program table
    word_t prog [num_rows][max_len];
    int    prog_len [num_rows];
    word_t exp_v0 [num_rows];
    logic  has_mem [num_rows];
    word_t mem_addr [num_rows];
    word_t mem_exp [num_rows];
    int    cur_row;
    int    cycles = 0;

    mips_cpu_bus dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .bus_rsp     (bus_rsp),
        .active      (active),
        .register_v0 (register_v0),
        .bus_req     (bus_req)
    );

    avalon_mem_model mem0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .stall_en (stall_en),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the CPU did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // instruction encoders
    function automatic word_t r_type(input int funct, input int rs, input int rt,
                                     input int rd, input int shamt);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), 6'(funct)};
    endfunction

    function automatic word_t i_type(input int op, input int rs, input int rt, input int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t j_type(input int op, input int index);
        word_t addr;
        addr = reset_vector + 32'(4 * index);
        return {6'(op), addr[27:2]};
    endfunction

    task automatic emit(input word_t w);
        prog[cur_row][prog_len[cur_row]] = w;
        prog_len[cur_row]++;
    endtask

    // every program ends by jumping to 0
    task automatic end_row(input word_t v0, input logic chk, input word_t addr, input word_t val);
        emit(r_type(8, 0, 0, 0, 0));    // jr $0
        emit(32'h0000_0000);            // nop in the delay slot
        exp_v0[cur_row]   = v0;
        has_mem[cur_row]  = chk;
        mem_addr[cur_row] = addr;
        mem_exp[cur_row]  = val;
        cur_row++;
    endtask

    task automatic build_table();
        // register ops and the three shifts
        emit(i_type(9, 0, 8, -5));           // addiu $8, $0, -5
        emit(i_type(9, 0, 9, 3));            // addiu $9, $0, 3
        emit(r_type(42, 8, 9, 10, 0));       // slt $10 = 1
        emit(r_type(43, 8, 9, 11, 0));       // sltu $11 = 0
        emit(r_type(3, 0, 8, 12, 1));        // sra $12 = fffffffd
        emit(r_type(2, 0, 8, 13, 28));       // srl $13 = f
        emit(r_type(0, 0, 9, 14, 4));        // sll $14 = 30
        emit(r_type(33, 10, 12, 2, 0));      // addu
        emit(r_type(38, 2, 13, 2, 0));       // xor
        emit(r_type(35, 2, 14, 2, 0));       // subu
        emit(r_type(37, 2, 13, 2, 0));       // or -> ffffffcf
        emit(r_type(36, 2, 12, 2, 0));       // and -> ffffffcd
        emit(r_type(33, 2, 11, 2, 0));       // adds the sltu result
        end_row(32'hffff_ffcd, 1'b0, '0, '0);
        // immediates and writes to $0
        emit(i_type(15, 0, 8, 'h1234));      // lui
        emit(i_type(13, 8, 8, 'h5678));      // ori -> 12345678
        emit(i_type(12, 8, 9, 'hff0f));      // andi -> 5608
        emit(i_type(14, 9, 10, 'hffff));     // xori -> a9f7
        emit(i_type(10, 8, 11, -1));         // slti -> 0
        emit(i_type(11, 8, 12, -1));         // sltiu -> 1
        emit(r_type(39, 10, 0, 13, 0));      // nor -> ffff5608
        emit(r_type(33, 13, 11, 2, 0));
        emit(r_type(33, 2, 12, 2, 0));
        emit(i_type(9, 0, 0, 5));            // addiu $0 is dropped
        emit(r_type(33, 2, 0, 2, 0));
        end_row(32'hffff_5609, 1'b0, '0, '0);
        // sw then sb at offset 1 and sh at offset 2
        emit(i_type(9, 0, 16, 'h1000));
        emit(i_type(15, 0, 8, 'h8899));
        emit(i_type(13, 8, 8, 'haabb));
        emit(i_type(43, 16, 8, 0));          // sw
        emit(i_type(9, 0, 9, 'h0011));
        emit(i_type(40, 16, 9, 1));          // sb
        emit(i_type(9, 0, 9, 'h7e2c));
        emit(i_type(41, 16, 9, 2));          // sh
        emit(i_type(35, 16, 2, 0));          // lw
        end_row(32'h7e2c_11bb, 1'b1, 32'h0000_1000, 32'h7e2c_11bb);
        // loads of every size and offset from word 80ff7f81
        emit(i_type(9, 0, 16, 'h1000));
        emit(i_type(15, 0, 8, 'h80ff));
        emit(i_type(13, 8, 8, 'h7f81));
        emit(i_type(43, 16, 8, 4));
        emit(i_type(32, 16, 9, 4));          // lb -> ffffff81
        emit(i_type(36, 16, 10, 5));         // lbu -> 7f
        emit(i_type(33, 16, 11, 6));         // lh -> ffff80ff
        emit(i_type(37, 16, 12, 4));         // lhu -> 7f81
        emit(i_type(32, 16, 13, 7));         // lb -> ffffff80
        emit(i_type(36, 16, 14, 6));         // lbu -> ff
        emit(i_type(37, 16, 15, 6));         // lhu -> 80ff
        emit(r_type(38, 9, 10, 2, 0));
        emit(r_type(38, 2, 11, 2, 0));
        emit(r_type(38, 2, 12, 2, 0));
        emit(r_type(35, 2, 13, 2, 0));
        emit(r_type(38, 2, 14, 2, 0));
        emit(r_type(38, 2, 15, 2, 0));
        end_row(32'h0000_8100, 1'b0, '0, '0);
        // sh at offset 0 and sb at offsets 3 down to 0
        emit(i_type(9, 0, 16, 'h1000));
        emit(i_type(9, 0, 8, -1));
        emit(i_type(43, 16, 8, 8));
        emit(i_type(9, 0, 10, 'h1234));
        emit(i_type(41, 16, 10, 8));         // sh -> ffff1234
        emit(i_type(9, 0, 9, 'h0055));
        emit(i_type(40, 16, 9, 11));
        emit(i_type(9, 0, 9, 'h0044));
        emit(i_type(40, 16, 9, 10));         // 55441234
        emit(i_type(9, 0, 9, 'h0066));
        emit(i_type(40, 16, 9, 9));
        emit(i_type(40, 16, 9, 8));          // 55446666
        emit(i_type(35, 16, 2, 8));
        end_row(32'h5544_6666, 1'b1, 32'h0000_1008, 32'h5544_6666);
        // branches whose delay slot always runs
        emit(i_type(9, 0, 2, 0));
        emit(i_type(9, 0, 8, 1));
        emit(i_type(4, 8, 0, 2));            // beq not taken
        emit(i_type(9, 2, 2, 1));
        emit(i_type(9, 2, 2, 2));
        emit(i_type(5, 8, 0, 2));            // bne taken
        emit(i_type(9, 2, 2, 4));
        emit(i_type(9, 2, 2, 8));            // skipped
        emit(i_type(4, 8, 8, 2));            // beq taken
        emit(i_type(9, 2, 2, 16));
        emit(i_type(9, 2, 2, 32));           // skipped
        emit(i_type(5, 8, 8, 1));            // bne not taken
        emit(i_type(9, 2, 2, 64));
        emit(i_type(9, 2, 2, 128));
        end_row(32'h0000_00d7, 1'b0, '0, '0);
        // jal, j, jalr and the link values
        emit(i_type(9, 0, 2, 0));
        emit(j_type(3, 6));                  // jal sets $31 to base + c
        emit(i_type(9, 2, 2, 1));
        emit(i_type(9, 2, 2, 2));
        emit(i_type(9, 2, 2, 4));
        emit(i_type(9, 2, 2, 8));
        emit(i_type(15, 0, 10, 'hbfc0));
        emit(r_type(35, 31, 10, 11, 0));
        emit(r_type(33, 2, 11, 2, 0));       // v0 = 13
        emit(j_type(2, 12));
        emit(i_type(9, 2, 2, 16));
        emit(i_type(9, 2, 2, 32));
        emit(i_type(15, 0, 12, 'hbfc0));
        emit(i_type(13, 12, 12, 'h0048));
        emit(r_type(9, 12, 0, 13, 0));       // jalr $13, $12
        emit(i_type(9, 2, 2, 64));
        emit(i_type(9, 2, 2, 128));
        emit(i_type(9, 2, 2, 256));
        emit(r_type(35, 13, 10, 14, 0));     // link offset 40
        emit(r_type(33, 2, 14, 2, 0));
        end_row(32'h0000_009d, 1'b0, '0, '0);
    endtask

    task automatic check_bus_idle();
        check_value("bus_req.read", 32'(bus_req.read), 32'd0);
        check_value("bus_req.write", 32'(bus_req.write), 32'd0);
    endtask

    task automatic run_row(input int r);
        logic seen_active;
        @(negedge clk);
        arst_n = 1'b0;
        mem0.clear();
        for (int i = 0; i < prog_len[r]; i++) begin
            mem0.poke(reset_vector + 32'(4 * i), prog[r][i]);
        end
        repeat (2) begin
            @(negedge clk);
            check_value("active", 32'(active), 32'd0);
            check_bus_idle();
        end
        arst_n      = 1'b1;
        seen_active = 1'b0;
        while (!seen_active || active) begin
            @(negedge clk);
            if (active) begin
                seen_active = 1'b1;
            end else begin
                check_bus_idle();   // nothing moves before start or after the halt
            end
        end
        repeat (3) begin
            @(negedge clk);
            check_value("active", 32'(active), 32'd0);
            check_bus_idle();
        end
        check_value("register_v0", register_v0, exp_v0[r]);
        if (has_mem[r]) begin
            check_value("memory word", mem0.peek(mem_addr[r]), mem_exp[r]);
        end
    endtask

    initial begin
        arst_n   = 1'b0;
        stall_en = 1'b0;
        cur_row  = 0;
        for (int r = 0; r < num_rows; r++) begin
            prog_len[r] = 0;
        end
        build_table();
        // first pass without stalls and second with random waitrequest
        for (int pass = 0; pass < 2; pass++) begin
            stall_en = pass == 1;
            for (int r = 0; r < num_rows; r++) begin
                run_row(r);
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* vlog.f */
logic/mips_isa_pkg.sv
logic/cpu_bus_pkg.sv
logic/control_unit.sv
logic/register_file.sv
logic/alu.sv
logic/load_store_align.sv
logic/mips_cpu_bus.sv
bench/avalon_mem_model.sv
bench/mips_cpu_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the CPU testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module mips_cpu_bus_tb -o mips_cpu_bus_sim \
    && ./obj_dir/mips_cpu_bus_sim | grep "SIMULATION PASSED" \
    && exit 0 \
    || exit 1
